// File: verilog/rv_core_pkg.sv
package rv_core_pkg;

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_system = 7'b1110011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } rv_inst_u;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_sltu, alu_sra} alu_op_e;
    typedef enum logic [1:0] {src_reg, src_imm, src_pc_imm, src_pc_four} alu_src_e;
    typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_fmt_e;
    typedef enum logic [1:0] {size_word, size_half, size_byte_u} mem_size_e;

    typedef struct packed {
        logic      reg_wen;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        imm_fmt_e  imm_fmt;
        alu_op_e   alu_op;
        alu_src_e  alu_src;
        logic      branch;
        logic      branch_ne;
        logic      jump;
        logic      jalr;
        logic      mem_rd;
        logic      mem_wr;
        mem_size_e mem_size;
        logic      halt;
        logic      illegal;
    } ctrl_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

// File: verilog/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  rv_core_pkg::rv_inst_u inst,
    output rv_core_pkg::ctrl_t    ctrl
);
    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst.r_fmt.opcode;
    assign funct3 = inst.r_fmt.funct3;
    assign funct7 = inst.r_fmt.funct7;

    always_comb begin
        ctrl          = '0;
        ctrl.imm_fmt  = imm_i;
        ctrl.alu_op   = alu_add;
        ctrl.alu_src  = src_reg;
        ctrl.mem_size = size_word;
        case (opcode)
            op_reg: begin
                ctrl.reg_wen = 1'b1;
                ctrl.rd      = inst.r_fmt.rd;
                ctrl.rs1     = inst.r_fmt.rs1;
                ctrl.rs2     = inst.r_fmt.rs2;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = alu_add;
                    {7'b0100000, 3'b000}: ctrl.alu_op = alu_sub;
                    {7'b0000000, 3'b111}: ctrl.alu_op = alu_and;
                    {7'b0000000, 3'b011}: ctrl.alu_op = alu_sltu;
                    default:              ctrl.illegal = 1'b1;
                endcase
            end
            op_imm: begin
                ctrl.reg_wen = 1'b1;
                ctrl.rd      = inst.i_fmt.rd;
                ctrl.rs1     = inst.i_fmt.rs1;
                ctrl.alu_src = src_imm;
                case (funct3)
                    3'b000: ctrl.alu_op = alu_add;
                    3'b111: ctrl.alu_op = alu_and;
                    3'b011: ctrl.alu_op = alu_sltu; // compares against sign-extended imm
                    3'b101: begin
                        ctrl.alu_op  = alu_sra;
                        ctrl.illegal = (funct7 != 7'b0100000); // srli not in subset
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            op_load: begin
                ctrl.reg_wen  = 1'b1;
                ctrl.mem_rd   = 1'b1;
                ctrl.rd       = inst.i_fmt.rd;
                ctrl.rs1      = inst.i_fmt.rs1;
                ctrl.alu_src  = src_imm;
                ctrl.mem_size = (funct3 == 3'b100) ? size_byte_u : size_word;
                ctrl.illegal  = (funct3 != 3'b010) && (funct3 != 3'b100);
            end
            op_store: begin
                ctrl.mem_wr   = 1'b1;
                ctrl.rs1      = inst.s_fmt.rs1;
                ctrl.rs2      = inst.s_fmt.rs2;
                ctrl.imm_fmt  = imm_s;
                ctrl.alu_src  = src_imm;
                ctrl.mem_size = (funct3 == 3'b001) ? size_half : size_word;
                ctrl.illegal  = (funct3 != 3'b010) && (funct3 != 3'b001);
            end
            op_branch: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = funct3[0];
                ctrl.rs1       = inst.b_fmt.rs1;
                ctrl.rs2       = inst.b_fmt.rs2;
                ctrl.imm_fmt   = imm_b;
                ctrl.illegal   = (funct3[2:1] != 2'b00); // beq, bne only
            end
            op_jal: begin
                ctrl.reg_wen = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.rd      = inst.j_fmt.rd;
                ctrl.imm_fmt = imm_j;
                ctrl.alu_src = src_pc_four; // link value
            end
            op_jalr: begin
                ctrl.reg_wen = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.jalr    = 1'b1;
                ctrl.rd      = inst.i_fmt.rd;
                ctrl.rs1     = inst.i_fmt.rs1;
                ctrl.alu_src = src_pc_four;
                ctrl.illegal = (funct3 != 3'b000);
            end
            op_lui: begin
                ctrl.reg_wen = 1'b1;
                ctrl.rd      = inst.u_fmt.rd;
                ctrl.imm_fmt = imm_u;
                ctrl.alu_src = src_imm; // x0 + imm
            end
            op_auipc: begin
                ctrl.reg_wen = 1'b1;
                ctrl.rd      = inst.u_fmt.rd;
                ctrl.imm_fmt = imm_u;
                ctrl.alu_src = src_pc_imm;
            end
            op_system: begin
                if (inst == 32'h0010_0073) begin
                    ctrl.halt = 1'b1; // ebreak
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            default: ctrl.illegal = 1'b1;
        endcase
        if (ctrl.illegal) begin
            ctrl         = '0; // no write, no memory access
            ctrl.illegal = 1'b1;
        end
    end

endmodule

// File: verilog/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        wen,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

// File: verilog/rv_exec.sv
`timescale 1ns/1ps

module rv_exec (
    input  rv_core_pkg::rv_inst_u inst,
    input  rv_core_pkg::ctrl_t    ctrl,
    input  logic [31:0]           pc,
    input  logic [31:0]           rdata1,
    input  logic [31:0]           rdata2,
    input  logic [31:0]           load_data,
    output logic [31:0]           result,
    output logic [31:0]           next_pc,
    output logic [31:0]           store_data,
    output logic [31:0]           wb_data
);
    import rv_core_pkg::*;

    logic [31:0] imm;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic        taken;

    always_comb begin
        case (ctrl.imm_fmt)
            imm_s:   imm = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
            imm_b:   imm = {{20{inst.b_fmt.imm_12}}, inst.b_fmt.imm_11, inst.b_fmt.imm_10_5,
                            inst.b_fmt.imm_4_1, 1'b0};
            imm_u:   imm = {inst.u_fmt.imm_31_12, 12'd0};
            imm_j:   imm = {{12{inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
                            inst.j_fmt.imm_10_1, 1'b0};
            default: imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
        endcase
    end

    always_comb begin
        case (ctrl.alu_src)
            src_imm:     begin op_a = rdata1; op_b = imm;   end
            src_pc_imm:  begin op_a = pc;     op_b = imm;   end
            src_pc_four: begin op_a = pc;     op_b = 32'd4; end
            default:     begin op_a = rdata1; op_b = rdata2; end
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            alu_sub:  result = op_a - op_b;
            alu_and:  result = op_a & op_b;
            alu_sltu: result = {31'd0, op_a < op_b};
            alu_sra:  result = $signed(op_a) >>> op_b[4:0]; // shamt in imm[4:0]
            default:  result = op_a + op_b;
        endcase
    end

    assign taken = ctrl.branch && ((rdata1 == rdata2) ^ ctrl.branch_ne);

    always_comb begin
        if (ctrl.jalr) begin
            next_pc = (rdata1 + imm) & ~32'd1;
        end else if (ctrl.jump || taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_comb begin
        case (ctrl.mem_size)
            size_half: store_data = {2{rdata2[15:0]}}; // lanes picked by sel
            default:   store_data = rdata2;
        endcase
    end

    assign wb_data = ctrl.mem_rd ? load_data : result;

endmodule

// File: verilog/rv_pc_unit.sv
`timescale 1ns/1ps

module rv_pc_unit #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic                  clk,
    input  logic                  arst_n,
    output rv_core_pkg::wb_req_t  wb_req,
    input  rv_core_pkg::wb_rsp_t  wb_rsp,
    input  rv_core_pkg::ctrl_t    ctrl,
    input  logic [31:0]           next_pc,
    input  logic                  lsu_done,
    output rv_core_pkg::rv_inst_u inst,
    output logic [31:0]           pc,
    output logic                  lsu_start,
    output logic                  retire,
    output logic                  halted,
    output logic                  illegal
);

    typedef enum logic [1:0] {st_fetch, st_exec, st_mem} state_e;

    state_e state;
    logic   ir_valid;
    logic   mem_op;
    logic   fetch_en;

    assign ir_valid  = (state == st_exec);
    assign mem_op    = ctrl.mem_rd | ctrl.mem_wr;
    assign lsu_start = ir_valid && mem_op;
    assign retire    = (ir_valid && !mem_op) || (state == st_mem && lsu_done);

    always_comb begin
        wb_req     = '0;
        wb_req.cyc = fetch_en && (state == st_fetch) && !halted; // no fetch once halted
        wb_req.stb = wb_req.cyc;
        wb_req.adr = {pc[31:2], 2'b00};
        wb_req.sel = 4'b1111;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_fetch;
            pc       <= reset_pc;
            fetch_en <= 1'b0; // bus idle while in reset
            halted   <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (state == st_fetch && wb_rsp.ack) begin
                state <= st_exec;
            end else if (lsu_start) begin
                state <= st_mem;
            end
            if (retire) begin
                state <= st_fetch;
                if (ctrl.halt || ctrl.illegal) begin
                    halted  <= 1'b1;
                    illegal <= ctrl.illegal;
                end else begin
                    pc <= next_pc;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_req.cyc && wb_rsp.ack) begin
            inst <= wb_rsp.dat; // instruction register
        end
    end

endmodule

// File: verilog/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,
    input  rv_core_pkg::ctrl_t   ctrl,
    input  logic [31:0]          addr,
    input  logic [31:0]          store_data,
    output rv_core_pkg::wb_req_t wb_req,
    input  rv_core_pkg::wb_rsp_t wb_rsp,
    output logic                 done,
    output logic [31:0]          load_data
);
    import rv_core_pkg::*;

    logic        busy;
    logic [31:0] addr_q;
    logic [31:0] data_q;
    logic        we_q;
    mem_size_e   size_q;
    logic [3:0]  sel;
    logic [31:0] rd_shift;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (wb_rsp.ack) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= addr;
            data_q <= store_data;
            we_q   <= ctrl.mem_wr;
            size_q <= ctrl.mem_size;
        end
    end

    always_comb begin
        case (size_q)
            size_half:   sel = addr_q[1] ? 4'b1100 : 4'b0011;
            size_byte_u: sel = 4'b0001 << addr_q[1:0];
            default:     sel = 4'b1111;
        endcase
    end

    assign wb_req = '{cyc: busy, stb: busy, we: we_q, adr: {addr_q[31:2], 2'b00},
                      dat: data_q, sel: sel};

    assign done     = busy & wb_rsp.ack;
    assign rd_shift = wb_rsp.dat >> {addr_q[1:0], 3'b000}; // addressed lane to bit 0

    always_comb begin
        case (size_q)
            size_byte_u: load_data = {24'd0, rd_shift[7:0]};
            default:     load_data = wb_rsp.dat;
        endcase
    end

endmodule

// File: verilog/rv_wb_arbiter.sv
`timescale 1ns/1ps

module rv_wb_arbiter (
    input  logic                 clk,
    input  logic                 arst_n,
    input  rv_core_pkg::wb_req_t fetch_req,
    output rv_core_pkg::wb_rsp_t fetch_rsp,
    input  rv_core_pkg::wb_req_t lsu_req,
    output rv_core_pkg::wb_rsp_t lsu_rsp,
    output rv_core_pkg::wb_req_t bus_req,
    input  rv_core_pkg::wb_rsp_t bus_rsp
);

    logic locked_q;
    logic owner_lsu_q;
    logic sel_lsu;

    // idle bus goes to lsu first, a running cycle keeps its owner
    assign sel_lsu = locked_q ? owner_lsu_q : lsu_req.cyc;
    assign bus_req = sel_lsu ? lsu_req : fetch_req;

    always_comb begin
        fetch_rsp     = bus_rsp;
        lsu_rsp       = bus_rsp;
        fetch_rsp.ack = bus_rsp.ack & ~sel_lsu;
        lsu_rsp.ack   = bus_rsp.ack & sel_lsu;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            locked_q    <= 1'b0;
            owner_lsu_q <= 1'b0;
        end else begin
            locked_q    <= bus_req.cyc & ~bus_rsp.ack; // released by ack
            owner_lsu_q <= sel_lsu;
        end
    end

endmodule

// File: verilog/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic                 clk,
    input  logic                 arst_n,
    output rv_core_pkg::wb_req_t bus_req,
    input  rv_core_pkg::wb_rsp_t bus_rsp,
    output logic                 halted,
    output logic                 illegal
);
    import rv_core_pkg::*;

    wb_req_t     fetch_req;
    wb_rsp_t     fetch_rsp;
    wb_req_t     lsu_req;
    wb_rsp_t     lsu_rsp;
    ctrl_t       ctrl;
    rv_inst_u    inst;
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] result;
    logic [31:0] store_data;
    logic [31:0] load_data;
    logic [31:0] wb_data;
    logic        lsu_start;
    logic        lsu_done;
    logic        retire;

    rv_pc_unit #(.reset_pc(reset_pc)) pc_unit_i (
        .clk, .arst_n, .wb_req(fetch_req), .wb_rsp(fetch_rsp), .ctrl, .next_pc,
        .lsu_done, .inst, .pc, .lsu_start, .retire, .halted, .illegal
    );

    rv_decode decode_i (.inst, .ctrl);

    rv_regfile regfile_i (
        .clk, .arst_n, .rs1(ctrl.rs1), .rs2(ctrl.rs2), .rd(ctrl.rd),
        .wen(retire & ctrl.reg_wen), .wdata(wb_data), .rdata1, .rdata2
    );

    rv_exec exec_i (
        .inst, .ctrl, .pc, .rdata1, .rdata2, .load_data, .result, .next_pc,
        .store_data, .wb_data
    );

    rv_lsu lsu_i (
        .clk, .arst_n, .start(lsu_start), .ctrl, .addr(result), .store_data,
        .wb_req(lsu_req), .wb_rsp(lsu_rsp), .done(lsu_done), .load_data
    );

    rv_wb_arbiter arbiter_i (
        .clk, .arst_n, .fetch_req, .fetch_rsp, .lsu_req, .lsu_rsp, .bus_req, .bus_rsp
    );

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real period_ns = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2.0) clk = ~clk;
        end
    end

endmodule

// File: dv/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
    import rv_core_pkg::*;

    localparam real clk_period_ns = 8.0;
    localparam int  reset_cycles  = 16;
    localparam int  idle_cycles   = 20;
    localparam int  cycle_bound   = 12; // worst case per instruction
    localparam logic [31:0] data_addr = 32'h200;

    localparam logic [6:0] opc_imm   = 7'b0010011;
    localparam logic [6:0] opc_load  = 7'b0000011;
    localparam logic [6:0] opc_jalr  = 7'b1100111;
    localparam logic [6:0] opc_lui   = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;

    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } store_row_t;

    logic        clk;
    logic        arst_n;
    wb_req_t     bus_req;
    wb_rsp_t     bus_rsp;
    logic        halted;
    logic        illegal;
    logic [31:0] mem [0:255];
    logic [31:0] prog [$];
    store_row_t  exp_stores [$];
    int          prog_b_start;
    int          rows_a;
    int          store_idx = 0;
    int          cycles_after_halt = 0;
    int          seed = 32'h72785680;
    logic        tables_built = 1'b0;

    tb_clk_gen #(.period_ns(clk_period_ns)) clk_gen_i (.clk);

    rv_core_top #(.reset_pc(32'h0)) dut_i (
        .clk, .arst_n, .bus_req, .bus_rsp, .halted, .illegal
    );

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("error %s: got 0x%08h, expected 0x%08h", name, got, expected));
        end
    endtask

    task automatic add_row(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
        store_row_t row;
        row.adr = adr;
        row.dat = dat;
        row.sel = sel;
        exp_stores.push_back(row);
    endtask

    task automatic build_tables();
        prog.push_back(i_word(12'd100, 5'd0, 3'b000, 5'd1, opc_imm));  // x1 = 100
        prog.push_back(i_word(12'hff9, 5'd0, 3'b000, 5'd2, opc_imm));  // x2 = -7
        prog.push_back(r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));       // add
        prog.push_back(s_word(12'h300, 5'd3, 5'd0, 3'b010));
        prog.push_back(r_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));       // sub
        prog.push_back(s_word(12'h304, 5'd4, 5'd0, 3'b010));
        prog.push_back(r_word(7'h00, 5'd1, 5'd2, 3'b111, 5'd5));       // and
        prog.push_back(s_word(12'h308, 5'd5, 5'd0, 3'b010));
        prog.push_back(r_word(7'h00, 5'd2, 5'd1, 3'b011, 5'd6));       // sltu
        prog.push_back(s_word(12'h30c, 5'd6, 5'd0, 3'b010));
        prog.push_back(i_word(12'h0f0, 5'd2, 3'b111, 5'd7, opc_imm));  // andi
        prog.push_back(s_word(12'h310, 5'd7, 5'd0, 3'b010));
        prog.push_back(i_word(12'hfff, 5'd1, 3'b011, 5'd8, opc_imm));  // sltiu against -1
        prog.push_back(s_word(12'h314, 5'd8, 5'd0, 3'b010));
        prog.push_back(i_word(12'h402, 5'd2, 3'b101, 5'd9, opc_imm));  // srai by 2
        prog.push_back(s_word(12'h318, 5'd9, 5'd0, 3'b010));
        prog.push_back(u_word(20'h12345, 5'd10, opc_lui));
        prog.push_back(s_word(12'h31c, 5'd10, 5'd0, 3'b010));
        prog.push_back(u_word(20'h00001, 5'd11, opc_auipc));           // at pc 0x48
        prog.push_back(s_word(12'h320, 5'd11, 5'd0, 3'b010));
        prog.push_back(i_word(12'h200, 5'd0, 3'b010, 5'd12, opc_load)); // lw
        prog.push_back(s_word(12'h324, 5'd12, 5'd0, 3'b010));
        prog.push_back(i_word(12'h202, 5'd0, 3'b100, 5'd13, opc_load)); // lbu byte 2
        prog.push_back(s_word(12'h328, 5'd13, 5'd0, 3'b010));
        prog.push_back(s_word(12'h32e, 5'd12, 5'd0, 3'b001));          // sh upper half
        prog.push_back(s_word(12'h32c, 5'd13, 5'd0, 3'b001));          // sh lower half
        prog.push_back(b_word(13'd8, 5'd8, 5'd6, 3'b000));             // beq taken
        prog.push_back(s_word(12'h330, 5'd1, 5'd0, 3'b010));
        prog.push_back(b_word(13'd8, 5'd8, 5'd6, 3'b001));             // bne not taken
        prog.push_back(s_word(12'h330, 5'd3, 5'd0, 3'b010));
        prog.push_back(b_word(13'd8, 5'd2, 5'd1, 3'b001));             // bne taken
        prog.push_back(s_word(12'h334, 5'd1, 5'd0, 3'b010));
        prog.push_back(b_word(13'd8, 5'd2, 5'd1, 3'b000));             // beq not taken
        prog.push_back(s_word(12'h334, 5'd4, 5'd0, 3'b010));
        prog.push_back(j_word(21'd12, 5'd14));                         // jal at 0x88
        prog.push_back(s_word(12'h338, 5'd1, 5'd0, 3'b010));
        prog.push_back(s_word(12'h338, 5'd1, 5'd0, 3'b010));
        prog.push_back(s_word(12'h338, 5'd14, 5'd0, 3'b010));
        prog.push_back(i_word(12'h0b0, 5'd0, 3'b000, 5'd15, opc_imm));
        prog.push_back(i_word(12'hff9, 5'd15, 3'b000, 5'd16, opc_jalr)); // odd target 0xa9
        prog.push_back(s_word(12'h33c, 5'd1, 5'd0, 3'b010));
        prog.push_back(s_word(12'h33c, 5'd1, 5'd0, 3'b010));
        prog.push_back(u_word(20'h00000, 5'd17, opc_auipc));           // pc seen at 0xa8
        prog.push_back(s_word(12'h33c, 5'd16, 5'd0, 3'b010));
        prog.push_back(s_word(12'h340, 5'd17, 5'd0, 3'b010));
        prog.push_back(32'h0010_0073);                                 // ebreak
        prog_b_start = prog.size();
        prog.push_back(i_word(12'd5, 5'd0, 3'b000, 5'd1, opc_imm));
        prog.push_back(s_word(12'h344, 5'd1, 5'd0, 3'b010));
        prog.push_back(r_word(7'h00, 5'd1, 5'd1, 3'b110, 5'd2));       // or, not supported

        add_row(32'h300, 32'h0000_005d, 4'hf);
        add_row(32'h304, 32'h0000_006b, 4'hf);
        add_row(32'h308, 32'h0000_0060, 4'hf);
        add_row(32'h30c, 32'h0000_0001, 4'hf);
        add_row(32'h310, 32'h0000_00f0, 4'hf);
        add_row(32'h314, 32'h0000_0001, 4'hf);
        add_row(32'h318, 32'hffff_fffe, 4'hf);
        add_row(32'h31c, 32'h1234_5000, 4'hf);
        add_row(32'h320, 32'h0000_1048, 4'hf);
        add_row(32'h324, 32'h8bad_f00d, 4'hf);
        add_row(32'h328, 32'h0000_00ad, 4'hf);
        add_row(32'h32c, 32'hf00d_f00d, 4'hc);
        add_row(32'h32c, 32'h00ad_00ad, 4'h3);
        add_row(32'h330, 32'h0000_005d, 4'hf);
        add_row(32'h334, 32'h0000_006b, 4'hf);
        add_row(32'h338, 32'h0000_008c, 4'hf);
        add_row(32'h33c, 32'h0000_00a0, 4'hf);
        add_row(32'h340, 32'h0000_00a8, 4'hf);
        rows_a = exp_stores.size();
        add_row(32'h344, 32'h0000_0005, 4'hf);
    endtask

    task automatic load_program(input int first, input int count);
        logic [31:0] byte_addr;
        for (int i = 0; i < 256; i++) begin
            byte_addr = i * 4;
            mem[i] = {~byte_addr[15:0], byte_addr[15:0]};
        end
        mem[data_addr[9:2]] = 32'h8bad_f00d; // load source
        for (int i = 0; i < count; i++) begin
            mem[i] = prog[first + i];
        end
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_for_halt();
        while (!halted) begin
            wait_cycle();
        end
    endtask

    task automatic check_reset_state();
        check_equal("bus_req.cyc", {31'd0, bus_req.cyc}, 32'd0);
        check_equal("halted", {31'd0, halted}, 32'd0);
        check_equal("illegal", {31'd0, illegal}, 32'd0);
    endtask

    task automatic check_store();
        store_row_t row;
        if (store_idx >= exp_stores.size()) begin
            abort_run("a store was issued beyond the end of the expected store table");
        end else begin
            row = exp_stores[store_idx];
            check_equal("bus_req.adr", bus_req.adr, row.adr);
            check_equal("bus_req.dat", bus_req.dat, row.dat);
            check_equal("bus_req.sel", {28'd0, bus_req.sel}, {28'd0, row.sel});
            store_idx++;
        end
    endtask

    task automatic serve_access();
        logic [7:0] idx;
        idx = bus_req.adr[9:2];
        if (bus_req.adr[31:10] != 22'd0) begin
            abort_run("the core accessed an address outside the test memory");
        end else begin
            if (bus_req.we) begin
                check_store();
                for (int b = 0; b < 4; b++) begin
                    if (bus_req.sel[b]) begin
                        mem[idx][8*b +: 8] = bus_req.dat[8*b +: 8];
                    end
                end
            end
            bus_rsp.ack = 1'b1;
            bus_rsp.dat = mem[idx];
        end
    endtask

    initial begin : memory_model
        logic rst_seen;
        logic pending;
        int   wait_left;
        bus_rsp   = '0;
        pending   = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            rst_seen = arst_n; // reset as seen by the core at this edge
            #1;
            bus_rsp = '0;
            if (!rst_seen || !arst_n) begin
                pending = 1'b0;
            end else if (bus_req.cyc && bus_req.stb) begin
                if (halted) begin
                    cycles_after_halt++;
                end
                if (!pending) begin
                    pending   = 1'b1;
                    wait_left = $unsigned($random(seed)) % 4; // 0 to 3 wait states
                end
                if (wait_left == 0) begin
                    pending = 1'b0;
                    serve_access();
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin : watchdog
        int limit_cycles;
        wait (tables_built);
        limit_cycles = prog.size() * cycle_bound + 2 * (reset_cycles + idle_cycles) + 16;
        #(limit_cycles * clk_period_ns);
        abort_run("timeout, the core did not finish the test programs in time");
    end

    initial begin : main
        arst_n = 1'b0;
        build_tables();
        tables_built = 1'b1;
        load_program(0, prog_b_start);
        repeat (reset_cycles) wait_cycle();
        check_reset_state();
        arst_n = 1'b1;
        wait_for_halt();
        check_equal("illegal", {31'd0, illegal}, 32'd0);
        check_equal("store_count", store_idx, rows_a);
        repeat (idle_cycles) wait_cycle();
        if (cycles_after_halt != 0) begin
            abort_run("bus cycles were issued after ebreak halted the core");
        end

        arst_n = 1'b0; // second run with an unsupported word
        load_program(prog_b_start, prog.size() - prog_b_start);
        repeat (reset_cycles) wait_cycle();
        check_reset_state();
        arst_n = 1'b1;
        wait_for_halt();
        check_equal("illegal", {31'd0, illegal}, 32'd1);
        check_equal("store_count", store_idx, exp_stores.size());
        repeat (idle_cycles) wait_cycle();
        if (cycles_after_halt != 0) begin
            abort_run("bus cycles were issued after the illegal word halted the core");
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: rv_core.f
verilog/rv_core_pkg.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_exec.sv
verilog/rv_pc_unit.sv
verilog/rv_lsu.sv
verilog/rv_wb_arbiter.sv
verilog/rv_core_top.sv
dv/tb_clk_gen.sv
dv/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
